//--- hw/pkt_buf_pkg.sv
`default_nettype none

package pkt_buf_pkg;

   // Buffer geometry
   localparam int BUF_AW    = 9;
   localparam int BUF_WORDS = 1 << BUF_AW;

   // Stream word layout
   localparam int WORD_W    = 36;
   localparam int PAYLOAD_W = 32;
   localparam int SOF_BIT   = 32;
   localparam int EOF_BIT   = 33;

   // One stream word, also the RAM word
   typedef logic [WORD_W-1:0] pkt_word_t;

   // Word address inside one buffer
   typedef logic [BUF_AW-1:0] buf_addr_t;

   // Packet length in words, one bit wider so a full buffer fits
   typedef logic [BUF_AW:0] pkt_len_t;

   // Life cycle of one buffer
   typedef enum logic [1:0] {
      EMPTY,
      FILLING,
      EDITING,
      DRAINING
   } buf_phase_t;

endpackage

`default_nettype wire

//--- hw/ram_2port.sv
`timescale 1ns/100ps
`default_nettype none

module ram_2port
   import pkt_buf_pkg::*;
(
   input  wire       clk,
   // Port A
   input  wire       ena_i,
   input  wire       wea_i,
   input  buf_addr_t addra_i,
   input  pkt_word_t dia_i,
   output pkt_word_t doa_o,
   // Port B
   input  wire       enb_i,
   input  wire       web_i,
   input  buf_addr_t addrb_i,
   input  pkt_word_t dib_i,
   output pkt_word_t dob_o
);

   pkt_word_t mem [BUF_WORDS];

   // Read-first on both ports, output holds while the port is disabled
   always @(posedge clk)
   begin
      if (ena_i)
      begin
         if (wea_i)
            mem[addra_i] <= dia_i;
         doa_o <= mem[addra_i];
      end
   end

   always @(posedge clk)
   begin
      if (enb_i)
      begin
         if (web_i)
            mem[addrb_i] <= dib_i;
         dob_o <= mem[addrb_i];
      end
   end

endmodule

`default_nettype wire

//--- hw/buf_sm.sv
`timescale 1ns/100ps
`default_nettype none

module buf_sm
   import pkt_buf_pkg::*;
(
   input  wire clk,
   input  wire rst_n_i,
   input  wire clear_i,

   // Fill side
   input  wire write_done_i,
   output wire write_ok_o,
   output wire write_ptr_o,

   // Editor side
   input  wire access_done_i,
   output wire access_ok_o,
   output wire access_ptr_o,

   // Drain side
   input  wire read_done_i,
   output wire read_ok_o,
   output wire read_ptr_o
);

   buf_phase_t phase_q [2];

   logic write_ptr_q;
   logic access_ptr_q;
   logic read_ptr_q;

   // Phase per buffer
   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         phase_q[0] <= EMPTY;
         phase_q[1] <= EMPTY;
      end
      else
      begin
         for (int i = 0; i < 2; i++)
         begin
            case (phase_q[i])
               // An empty buffer is claimed once the fill side points at it
               EMPTY:
                  if (write_ptr_q == 1'(i))
                     phase_q[i] <= FILLING;
               FILLING:
                  if (write_done_i && write_ptr_q == 1'(i))
                     phase_q[i] <= EDITING;
               EDITING:
                  if (access_done_i && access_ptr_q == 1'(i))
                     phase_q[i] <= DRAINING;
               DRAINING:
                  if (read_done_i && read_ptr_q == 1'(i))
                     phase_q[i] <= EMPTY;
               default:
                  phase_q[i] <= EMPTY;
            endcase
         end
      end
   end

   // Each side moves to the other buffer once it is done with its own
   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         write_ptr_q  <= 1'b0;
         access_ptr_q <= 1'b0;
         read_ptr_q   <= 1'b0;
      end
      else
      begin
         if (write_done_i)
            write_ptr_q <= ~write_ptr_q;
         if (access_done_i)
            access_ptr_q <= ~access_ptr_q;
         if (read_done_i)
            read_ptr_q <= ~read_ptr_q;
      end
   end

   assign write_ok_o   = (phase_q[write_ptr_q] == FILLING);
   assign access_ok_o  = (phase_q[access_ptr_q] == EDITING);
   assign read_ok_o    = (phase_q[read_ptr_q] == DRAINING);

   assign write_ptr_o  = write_ptr_q;
   assign access_ptr_o = access_ptr_q;
   assign read_ptr_o   = read_ptr_q;

   // A done strobe is only legal from the side that owns a buffer
   property p_done_owned(done, ok);
      @(posedge clk) disable iff (!rst_n_i || clear_i)
         done |-> ok;
   endproperty

   a_write_done_owned: assert property (p_done_owned(write_done_i, write_ok_o));
   a_access_done_owned: assert property (p_done_owned(access_done_i, access_ok_o));
   a_read_done_owned: assert property (p_done_owned(read_done_i, read_ok_o));

endmodule

`default_nettype wire

//--- hw/double_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module double_buffer
   import pkt_buf_pkg::*;
(
   input  wire       clk,
   input  wire       rst_n_i,
   input  wire       clear_i,

   // Input stream
   input  pkt_word_t data_i,
   input  wire       src_rdy_i,
   output wire       dst_rdy_o,

   // Output stream
   output pkt_word_t data_o,
   output wire       src_rdy_o,
   input  wire       dst_rdy_i,

   // Editor access port
   output wire       acc_ok_o,
   output pkt_len_t  acc_len_o,
   input  wire       acc_stb_i,
   input  wire       acc_we_i,
   input  buf_addr_t acc_adr_i,
   input  pkt_word_t acc_dat_i,
   output pkt_word_t acc_dat_o,
   input  wire       acc_done_i
);

   typedef enum logic [1:0] {
      IDLE,
      PRE_READ,
      READING
   } drain_state_t;

   logic write_ok, write_ptr, write_done;
   logic access_ok, access_ptr;
   logic read_ok, read_ptr, read_done;

   logic      write_en;
   logic      read_en;
   buf_addr_t fill_adr_q;
   buf_addr_t read_adr_q;
   pkt_len_t  len_q [2];

   drain_state_t drain_q;

   pkt_word_t doa [2];
   pkt_word_t dob [2];

   buf_sm buf_sm_i (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .clear_i       (clear_i),
      .write_done_i  (write_done),
      .write_ok_o    (write_ok),
      .write_ptr_o   (write_ptr),
      .access_done_i (acc_done_i),
      .access_ok_o   (access_ok),
      .access_ptr_o  (access_ptr),
      .read_done_i   (read_done),
      .read_ok_o     (read_ok),
      .read_ptr_o    (read_ptr)
   );

   // Port A belongs to the editor, port B is shared by fill and drain
   for (genvar b = 0; b < 2; b++)
   begin : g_buf
      logic      sel_fill;
      logic      sel_drain;
      buf_addr_t adr_b;

      assign sel_fill  = write_ok && (write_ptr == 1'(b));
      assign sel_drain = read_ok && (read_ptr == 1'(b));
      assign adr_b     = sel_fill ? fill_adr_q : read_adr_q;

      ram_2port ram_i (
         .clk     (clk),
         .ena_i   (acc_stb_i && access_ok && (access_ptr == 1'(b))),
         .wea_i   (acc_we_i),
         .addra_i (acc_adr_i),
         .dia_i   (acc_dat_i),
         .doa_o   (doa[b]),
         .enb_i   ((write_en && sel_fill) || (read_en && sel_drain)),
         .web_i   (write_en && sel_fill),
         .addrb_i (adr_b),
         .dib_i   (data_i),
         .dob_o   (dob[b])
      );
   end

   // Fill side
   assign dst_rdy_o  = write_ok;
   assign write_en   = src_rdy_i && write_ok;
   assign write_done = write_en && data_i[EOF_BIT];

   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
         fill_adr_q <= '0;
      else if (write_done)
         fill_adr_q <= '0;
      else if (write_en)
         fill_adr_q <= fill_adr_q + 1'b1;
   end

   // Length is taken from the address of the EOF word
   always_ff @(posedge clk)
   begin
      if (write_done)
         len_q[write_ptr] <= {1'b0, fill_adr_q} + pkt_len_t'(1);
   end

   // Editor side
   assign acc_ok_o  = access_ok;
   assign acc_len_o = len_q[access_ptr];
   assign acc_dat_o = doa[access_ptr];

   // PRE_READ primes the RAM output register with word 0
   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         drain_q    <= IDLE;
         read_adr_q <= '0;
      end
      else
      begin
         case (drain_q)
            IDLE:
            begin
               read_adr_q <= '0;
               if (read_ok)
                  drain_q <= PRE_READ;
            end
            PRE_READ:
            begin
               read_adr_q <= buf_addr_t'(1);
               drain_q    <= READING;
            end
            READING:
               if (dst_rdy_i)
               begin
                  read_adr_q <= read_adr_q + 1'b1;
                  if (data_o[EOF_BIT])
                     drain_q <= IDLE;
               end
            default:
               drain_q <= IDLE;
         endcase
      end
   end

   // Stalled output freezes both the RAM output and the address
   assign read_en   = !((drain_q == READING) && !dst_rdy_i);
   assign data_o    = dob[read_ptr];
   assign src_rdy_o = (drain_q == READING);
   assign read_done = src_rdy_o && dst_rdy_i && data_o[EOF_BIT];

   // A word without EOF on the last address would wrap into word 0
   a_fill_no_wrap: assert property (
      @(posedge clk) disable iff (!rst_n_i || clear_i)
         (write_en && !data_i[EOF_BIT]) |-> (fill_adr_q != buf_addr_t'(BUF_WORDS - 1))
   );

endmodule

`default_nettype wire

//--- hw/pkt_editor.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_editor
   import pkt_buf_pkg::*;
(
   input  wire       clk,
   input  wire       rst_n_i,
   input  wire       clear_i,

   input  wire       acc_ok_i,
   input  pkt_len_t  acc_len_i,
   output wire       acc_stb_o,
   output wire       acc_we_o,
   output buf_addr_t acc_adr_o,
   output pkt_word_t acc_dat_o,
   input  pkt_word_t acc_dat_i,
   output wire       acc_done_o
);

   typedef enum logic [2:0] {
      IDLE,
      RD,
      WAIT,
      WR,
      DONE
   } ed_state_t;

   ed_state_t state_q;
   buf_addr_t adr_q;
   pkt_word_t word_q;
   logic      last_word;

   assign last_word = (({1'b0, adr_q} + pkt_len_t'(1)) == acc_len_i);

   // Three cycles per word: read, wait for RAM data, write back
   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         state_q <= IDLE;
         adr_q   <= '0;
      end
      else
      begin
         case (state_q)
            IDLE:
               if (acc_ok_i)
               begin
                  adr_q   <= '0;
                  state_q <= RD;
               end
            RD:
               state_q <= WAIT;
            WAIT:
               state_q <= WR;
            WR:
               if (last_word)
                  state_q <= DONE;
               else
               begin
                  adr_q   <= adr_q + 1'b1;
                  state_q <= RD;
               end
            DONE:
               state_q <= IDLE;
            default:
               state_q <= IDLE;
         endcase
      end
   end

   // RAM read data is valid in WAIT
   always_ff @(posedge clk)
   begin
      if (state_q == WAIT)
         word_q <= acc_dat_i;
   end

   assign acc_stb_o  = (state_q == RD) || (state_q == WR);
   assign acc_we_o   = (state_q == WR);
   assign acc_adr_o  = adr_q;
   assign acc_done_o = (state_q == DONE);

   // Flag bits pass through, payload wraps modulo 2^32
   assign acc_dat_o = {word_q[WORD_W-1:PAYLOAD_W], word_q[PAYLOAD_W-1:0] + PAYLOAD_W'(1)};

   // Accesses only while the buffer still belongs to the editor
   a_stb_owned: assert property (
      @(posedge clk) disable iff (!rst_n_i || clear_i)
         acc_stb_o |-> acc_ok_i
   );

endmodule

`default_nettype wire

//--- hw/pkt_proc_top.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_proc_top
   import pkt_buf_pkg::*;
(
   input  wire       clk,
   input  wire       rst_n_i,
   input  wire       clear_i,

   // Input stream
   input  pkt_word_t data_i,
   input  wire       src_rdy_i,
   output wire       dst_rdy_o,

   // Output stream
   output pkt_word_t data_o,
   output wire       src_rdy_o,
   input  wire       dst_rdy_i
);

   wire       acc_ok;
   pkt_len_t  acc_len;
   wire       acc_stb;
   wire       acc_we;
   buf_addr_t acc_adr;
   pkt_word_t acc_wr_dat;
   pkt_word_t acc_rd_dat;
   wire       acc_done;

   double_buffer double_buffer_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .clear_i    (clear_i),
      .data_i     (data_i),
      .src_rdy_i  (src_rdy_i),
      .dst_rdy_o  (dst_rdy_o),
      .data_o     (data_o),
      .src_rdy_o  (src_rdy_o),
      .dst_rdy_i  (dst_rdy_i),
      .acc_ok_o   (acc_ok),
      .acc_len_o  (acc_len),
      .acc_stb_i  (acc_stb),
      .acc_we_i   (acc_we),
      .acc_adr_i  (acc_adr),
      .acc_dat_i  (acc_wr_dat),
      .acc_dat_o  (acc_rd_dat),
      .acc_done_i (acc_done)
   );

   pkt_editor pkt_editor_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .clear_i    (clear_i),
      .acc_ok_i   (acc_ok),
      .acc_len_i  (acc_len),
      .acc_stb_o  (acc_stb),
      .acc_we_o   (acc_we),
      .acc_adr_o  (acc_adr),
      .acc_dat_o  (acc_wr_dat),
      .acc_dat_i  (acc_rd_dat),
      .acc_done_o (acc_done)
   );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
   parameter real PERIOD_NS = 4.0
)
(
   output logic clk_o
);

   // Free running, starts low
   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

//--- testbench/pkt_proc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_proc_tb
   import pkt_buf_pkg::*;
();

   localparam integer SEED     = 32'h7a9c4914;
   localparam integer MAX_LEN  = 40;
   // Roughly 23 packets, rounded up, four cycles per word and a margin of five
   localparam integer NUM_PKTS       = 25;
   localparam integer TIMEOUT_CYCLES = NUM_PKTS * MAX_LEN * 4 * 5;

   wire       clk;
   logic      rst_n_i;
   logic      clear_i;
   pkt_word_t data_i;
   logic      src_rdy_i;
   wire       dst_rdy_o;
   pkt_word_t data_o;
   wire       src_rdy_o;
   logic      dst_rdy_i;

   integer    seed;
   integer    bp_seed;
   logic      bp_en;
   pkt_word_t exp_q [$];
   logic      held_valid;
   pkt_word_t held_data;
   int        stall_cycles;
   int        hold_cycles;
   int        cycle_count;

   tb_clk_gen #(.PERIOD_NS(4.0)) tb_clk_gen_i (.clk_o(clk));

   pkt_proc_top pkt_proc_top_i (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .clear_i   (clear_i),
      .data_i    (data_i),
      .src_rdy_i (src_rdy_i),
      .dst_rdy_o (dst_rdy_o),
      .data_o    (data_o),
      .src_rdy_o (src_rdy_o),
      .dst_rdy_i (dst_rdy_i)
   );

   // Expected output word has the payload plus one and the flag bits untouched
   function automatic pkt_word_t edited_word(input pkt_word_t w);
      edited_word = w;
      edited_word[31:0] = w[31:0] + 32'd1;
   endfunction

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [35:0] got,
                              input logic [35:0] exp);
      if (got !== exp)
         stop_with_failure($sformatf("CHECK FAILED: %s got %h expected %h", name, got, exp));
   endtask

   // Called just after a rising edge, returns just after the edge that took the word
   task automatic drive_word(input pkt_word_t w);
      logic accepted;
      int   waits;
      accepted  = 1'b0;
      waits     = 0;
      data_i    = w;
      src_rdy_i = 1'b1;
      while (!accepted)
      begin
         @(negedge clk);
         if (dst_rdy_o)
            accepted = 1'b1;
         else
         begin
            // A single wait is only the next buffer being claimed
            waits++;
            if (waits > 1)
               stall_cycles++;
         end
         @(posedge clk);
         #1;
      end
      exp_q.push_back(edited_word(w));
      src_rdy_i = 1'b0;
   endtask

   task automatic send_packet(input int len, input logic all_ones);
      pkt_word_t w;
      for (int i = 0; i < len; i++)
      begin
         w[31:0]    = all_ones ? 32'hffff_ffff : $random(seed);
         w[SOF_BIT] = (i == 0);
         w[EOF_BIT] = (i == len - 1);
         w[35:34]   = $random(seed);
         drive_word(w);
      end
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0)
         @(posedge clk);
      @(posedge clk);
      #1;
   endtask

   // Output side is sampled mid cycle where everything has settled
   always @(negedge clk)
   begin
      if (rst_n_i && !clear_i)
      begin
         if (held_valid)
         begin
            check_value("src_rdy_o", src_rdy_o, 1);
            check_value("data_o", data_o, held_data);
         end
         if (src_rdy_o && dst_rdy_i)
         begin
            if (exp_q.size() == 0)
               stop_with_failure("An output word arrived while no word was expected");
            else
               check_value("data_o", data_o, exp_q.pop_front());
         end
         if (src_rdy_o && !dst_rdy_i)
            hold_cycles++;
         held_valid = src_rdy_o && !dst_rdy_i;
         held_data  = data_o;
      end
      else
         held_valid = 1'b0;
   end

   // Output back-pressure
   always @(posedge clk)
   begin
      #1;
      if (bp_en)
         dst_rdy_i = ($random(bp_seed) % 3) != 0;
      else
         dst_rdy_i = 1'b1;
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
         stop_with_failure($sformatf("Timeout after %0d cycles, the packets did not come out",
                                     cycle_count));
   end

   initial
   begin
      seed         = SEED;
      bp_seed      = SEED ^ 32'h1f2e3d4c;
      rst_n_i      = 1'b0;
      clear_i      = 1'b0;
      data_i       = '0;
      src_rdy_i    = 1'b0;
      dst_rdy_i    = 1'b1;
      bp_en        = 1'b0;
      held_valid   = 1'b0;
      held_data    = '0;
      stall_cycles = 0;
      hold_cycles  = 0;
      cycle_count  = 0;

      repeat (2) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      // Both buffers still EMPTY for one cycle
      @(negedge clk);
      check_value("dst_rdy_o", dst_rdy_o, 0);
      check_value("src_rdy_o", src_rdy_o, 0);
      @(posedge clk);
      #1;

      send_packet(8, 1'b0);
      wait_drained();

      send_packet(1, 1'b0);
      wait_drained();

      // Back to back packets stall the input since the editor is slower than the fill
      stall_cycles = 0;
      for (int p = 0; p < 10; p++)
         send_packet(1 + ($unsigned($random(seed)) % MAX_LEN), 1'b0);
      wait_drained();
      if (stall_cycles == 0)
         stop_with_failure("dst_rdy_o never held the input while both buffers were busy");

      bp_en       = 1'b1;
      hold_cycles = 0;
      for (int p = 0; p < 8; p++)
         send_packet(1 + ($unsigned($random(seed)) % MAX_LEN), 1'b0);
      wait_drained();
      bp_en = 1'b0;
      if (hold_cycles == 0)
         stop_with_failure("The output stream was never held by back-pressure");

      // Payload wraps to zero
      send_packet(4, 1'b1);
      wait_drained();

      // Clear while the packet is still being edited
      send_packet(12, 1'b0);
      clear_i = 1'b1;
      @(posedge clk);
      #1;
      clear_i = 1'b0;
      exp_q.delete();
      @(negedge clk);
      check_value("dst_rdy_o", dst_rdy_o, 0);
      repeat (60)
      begin
         @(negedge clk);
         check_value("src_rdy_o", src_rdy_o, 0);
      end
      @(posedge clk);
      #1;
      send_packet(6, 1'b0);
      wait_drained();

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
hw/pkt_buf_pkg.sv
hw/ram_2port.sv
hw/buf_sm.sv
hw/double_buffer.sv
hw/pkt_editor.sv
hw/pkt_proc_top.sv
testbench/tb_clk_gen.sv
testbench/pkt_proc_tb.sv
